// ==== design/alu_exec.sv ====
`timescale 1ns/10ps

module alu_exec
import ooo_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              iss_valid,
    input  alu_op_t           iss_op,
    input  logic              iss_use_imm,
    input  logic [XLEN-1:0]   iss_imm,
    input  logic [PREG_W-1:0] iss_prd,
    input  logic [ROB_W-1:0]  iss_rob,
    input  logic [XLEN-1:0]   val1,
    input  logic [XLEN-1:0]   val2,
    output logic              cdb_valid,
    output logic [PREG_W-1:0] cdb_preg,
    output logic [ROB_W-1:0]  cdb_rob,
    output logic [XLEN-1:0]   cdb_data
);

logic [XLEN-1:0] opnd_b;
logic [4:0]      shamt;
logic [XLEN-1:0] result;

assign opnd_b = iss_use_imm ? iss_imm : val2;
assign shamt  = opnd_b[4:0];

always_comb begin
    case (iss_op)
        SUB:     result = val1 - opnd_b;
        SLL:     result = val1 << shamt;
        SLT:     result = {31'b0, $signed(val1) < $signed(opnd_b)};
        SLTU:    result = {31'b0, val1 < opnd_b};
        XOR:     result = val1 ^ opnd_b;
        SRL:     result = val1 >> shamt;
        SRA:     result = $unsigned($signed(val1) >>> shamt);
        OR:      result = val1 | opnd_b;
        AND:     result = val1 & opnd_b;
        PASS_B:  result = opnd_b;
        default: result = val1 + opnd_b;
    endcase
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cdb_valid <= 1'b0;
    end else begin
        cdb_valid <= iss_valid;
    end
end

always_ff @(posedge clk) begin
    cdb_preg <= iss_prd;
    cdb_rob  <= iss_rob;
    cdb_data <= result;
end

endmodule : alu_exec

// ==== design/inst_decode.sv ====
`timescale 1ns/10ps

module inst_decode
import ooo_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  logic [XLEN-1:0]   inst,
    output logic              dec_valid,
    output alu_op_t           dec_op,
    output logic              dec_use_imm,
    output logic [XLEN-1:0]   dec_imm,
    output logic [AREG_W-1:0] dec_rs1,
    output logic [AREG_W-1:0] dec_rs2,
    output logic [AREG_W-1:0] dec_rd
);

opcode_t           opcode;
alu_op_t           alu_sel;
alu_op_t           op_nxt;
logic              use_imm_nxt;
logic [XLEN-1:0]   imm_nxt;
logic [AREG_W-1:0] rs1_nxt;
logic [AREG_W-1:0] rs2_nxt;
logic [AREG_W-1:0] rd_nxt;

assign opcode = opcode_t'(inst[6:0]);

// funct3 picks the operation, bit 30 splits ADD/SUB and SRL/SRA
always_comb begin
    unique case (inst[14:12])
        3'b000:  alu_sel = (opcode == OP && inst[30]) ? SUB : ADD;
        3'b001:  alu_sel = SLL;
        3'b010:  alu_sel = SLT;
        3'b011:  alu_sel = SLTU;
        3'b100:  alu_sel = XOR;
        3'b101:  alu_sel = inst[30] ? SRA : SRL;
        3'b110:  alu_sel = OR;
        default: alu_sel = AND;
    endcase
end

always_comb begin
    op_nxt      = ADD;
    use_imm_nxt = 1'b0;
    imm_nxt     = {{20{inst[31]}}, inst[31:20]};
    rs1_nxt     = inst[19:15];
    rs2_nxt     = inst[24:20];
    rd_nxt      = inst[11:7];
    case (opcode)
        OP: begin
            op_nxt = alu_sel;
        end
        OP_IMM: begin
            op_nxt      = alu_sel;
            use_imm_nxt = 1'b1;
            rs2_nxt     = '0;
        end
        LUI: begin
            op_nxt      = PASS_B;
            use_imm_nxt = 1'b1;
            imm_nxt     = {inst[31:12], 12'b0};
            rs1_nxt     = '0;
            rs2_nxt     = '0;
        end
        default: begin
            // Unknown opcode retires as a harmless write to x0
            rs1_nxt = '0;
            rs2_nxt = '0;
            rd_nxt  = '0;
        end
    endcase
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        dec_valid <= 1'b0;
    end else begin
        dec_valid <= inst_valid;
    end
end

always_ff @(posedge clk) begin
    if (inst_valid) begin
        dec_op      <= op_nxt;
        dec_use_imm <= use_imm_nxt;
        dec_imm     <= imm_nxt;
        dec_rs1     <= rs1_nxt;
        dec_rs2     <= rs2_nxt;
        dec_rd      <= rd_nxt;
    end
end

endmodule : inst_decode

// ==== design/issue_queue.sv ====
`timescale 1ns/10ps

module issue_queue
import ooo_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ren_valid,
    input  alu_op_t           ren_op,
    input  logic              ren_use_imm,
    input  logic [XLEN-1:0]   ren_imm,
    input  logic [PREG_W-1:0] ren_prs1,
    input  logic [PREG_W-1:0] ren_prs2,
    input  logic [PREG_W-1:0] ren_prd,
    input  logic [ROB_W-1:0]  ren_rob,
    output logic [PREG_W-1:0] rd_prs1,
    output logic [PREG_W-1:0] rd_prs2,
    input  logic              rdy1,
    input  logic              rdy2,
    output logic              iss_valid,
    output alu_op_t           iss_op,
    output logic              iss_use_imm,
    output logic [XLEN-1:0]   iss_imm,
    output logic [PREG_W-1:0] iss_prd,
    output logic [ROB_W-1:0]  iss_rob
);

// Entry 0 is always the oldest
alu_op_t           q_op      [ROB_DEPTH];
logic              q_use_imm [ROB_DEPTH];
logic [XLEN-1:0]   q_imm     [ROB_DEPTH];
logic [PREG_W-1:0] q_prs1    [ROB_DEPTH];
logic [PREG_W-1:0] q_prs2    [ROB_DEPTH];
logic [PREG_W-1:0] q_prd     [ROB_DEPTH];
logic [ROB_W-1:0]  q_rob     [ROB_DEPTH];
logic [ROB_W:0]    count;
logic [ROB_W:0]    ins_idx;
logic [ROB_W-1:0]  probe;

// Scan walks from the oldest entry, one probe per cycle
assign rd_prs1 = q_prs1[probe];
assign rd_prs2 = q_prs2[probe];

assign iss_valid   = ({1'b0, probe} < count) && rdy1 && (q_use_imm[probe] || rdy2);
assign iss_op      = q_op[probe];
assign iss_use_imm = q_use_imm[probe];
assign iss_imm     = q_imm[probe];
assign iss_prd     = q_prd[probe];
assign iss_rob     = q_rob[probe];

// New entry lands behind the survivors of this cycle
assign ins_idx = count - (ROB_W+1)'(iss_valid);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        count <= '0;
        probe <= '0;
    end else begin
        count <= count + (ROB_W+1)'(ren_valid) - (ROB_W+1)'(iss_valid);
        // Restart at the oldest after an issue or at the end of the queue
        if (iss_valid || ({1'b0, probe} + 1'b1 >= count)) begin
            probe <= '0;
        end else begin
            probe <= probe + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (iss_valid) begin
        for (int i = 0; i < ROB_DEPTH - 1; i++) begin
            if (i >= int'(probe)) begin
                q_op[i]      <= q_op[i+1];
                q_use_imm[i] <= q_use_imm[i+1];
                q_imm[i]     <= q_imm[i+1];
                q_prs1[i]    <= q_prs1[i+1];
                q_prs2[i]    <= q_prs2[i+1];
                q_prd[i]     <= q_prd[i+1];
                q_rob[i]     <= q_rob[i+1];
            end
        end
    end
    if (ren_valid) begin
        q_op[ins_idx[ROB_W-1:0]]      <= ren_op;
        q_use_imm[ins_idx[ROB_W-1:0]] <= ren_use_imm;
        q_imm[ins_idx[ROB_W-1:0]]     <= ren_imm;
        q_prs1[ins_idx[ROB_W-1:0]]    <= ren_prs1;
        q_prs2[ins_idx[ROB_W-1:0]]    <= ren_prs2;
        q_prd[ins_idx[ROB_W-1:0]]     <= ren_prd;
        q_rob[ins_idx[ROB_W-1:0]]     <= ren_rob;
    end
end

endmodule : issue_queue

// ==== design/ooo_core.sv ====
`timescale 1ns/10ps

module ooo_core
import ooo_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  logic [XLEN-1:0]   inst,
    output logic              credit_return,
    output logic              commit_valid,
    output logic [AREG_W-1:0] commit_rd,
    output logic [XLEN-1:0]   commit_data
);

// Decode to rename
logic              dec_valid;
alu_op_t           dec_op;
logic              dec_use_imm;
logic [XLEN-1:0]   dec_imm;
logic [AREG_W-1:0] dec_rs1;
logic [AREG_W-1:0] dec_rs2;
logic [AREG_W-1:0] dec_rd;

// Rename to issue queue, register file and ROB
logic              ren_valid;
alu_op_t           ren_op;
logic              ren_use_imm;
logic [XLEN-1:0]   ren_imm;
logic [PREG_W-1:0] ren_prs1;
logic [PREG_W-1:0] ren_prs2;
logic [PREG_W-1:0] ren_prd;
logic [PREG_W-1:0] ren_old_prd;
logic [AREG_W-1:0] ren_rd;
logic [ROB_W-1:0]  ren_rob;

// Issue, operand read and execute
logic [PREG_W-1:0] rd_prs1;
logic [PREG_W-1:0] rd_prs2;
logic              rdy1;
logic              rdy2;
logic [XLEN-1:0]   val1;
logic [XLEN-1:0]   val2;
logic              iss_valid;
alu_op_t           iss_op;
logic              iss_use_imm;
logic [XLEN-1:0]   iss_imm;
logic [PREG_W-1:0] iss_prd;
logic [ROB_W-1:0]  iss_rob;

// Common data bus and commit-side free
logic              cdb_valid;
logic [PREG_W-1:0] cdb_preg;
logic [ROB_W-1:0]  cdb_rob;
logic [XLEN-1:0]   cdb_data;
logic              free_valid;
logic [PREG_W-1:0] free_preg;

// Port names match the wires above
inst_decode    inst_decode_inst    (.*);
rename_stage   rename_stage_inst   (.*);
issue_queue    issue_queue_inst    (.*);
phys_reg_file  phys_reg_file_inst  (.*);
alu_exec       alu_exec_inst       (.*);
reorder_buffer reorder_buffer_inst (.*);

endmodule : ooo_core

// ==== design/ooo_pkg.sv ====
package ooo_pkg;

// Datapath and register file sizes
localparam int XLEN      = 32;
localparam int ARCH_REGS = 32;
localparam int ROB_DEPTH = 8;
localparam int PHYS_REGS = ARCH_REGS + ROB_DEPTH;

// Index widths
localparam int AREG_W = $clog2(ARCH_REGS);
localparam int PREG_W = $clog2(PHYS_REGS);
localparam int ROB_W  = $clog2(ROB_DEPTH);

// Source side starts with one credit per ROB entry
localparam int INIT_CREDITS = ROB_DEPTH;

// Major opcodes of the supported subset
typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
} opcode_t;

// ALU operations
typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10
} alu_op_t;

endpackage : ooo_pkg

// ==== design/phys_reg_file.sv ====
`timescale 1ns/10ps

module phys_reg_file
import ooo_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ren_valid,
    input  logic [PREG_W-1:0] ren_prd,
    input  logic [PREG_W-1:0] rd_prs1,
    input  logic [PREG_W-1:0] rd_prs2,
    output logic              rdy1,
    output logic              rdy2,
    output logic [XLEN-1:0]   val1,
    output logic [XLEN-1:0]   val2,
    input  logic              cdb_valid,
    input  logic [PREG_W-1:0] cdb_preg,
    input  logic [XLEN-1:0]   cdb_data
);

logic [XLEN-1:0]      regs [PHYS_REGS];
logic [PHYS_REGS-1:0] ready;

// Initial mapping i -> i must read as zero
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        ready <= '1;
        for (int i = 0; i < PHYS_REGS; i++) begin
            regs[i] <= '0;
        end
    end else begin
        if (ren_valid && ren_prd != '0) begin
            ready[ren_prd] <= 1'b0;
        end
        // phys reg 0 backs x0
        if (cdb_valid && cdb_preg != '0) begin
            regs[cdb_preg]  <= cdb_data;
            ready[cdb_preg] <= 1'b1;
        end
    end
end

assign rdy1 = ready[rd_prs1];
assign rdy2 = ready[rd_prs2];
assign val1 = regs[rd_prs1];
assign val2 = regs[rd_prs2];

endmodule : phys_reg_file

// ==== design/rename_stage.sv ====
`timescale 1ns/10ps

module rename_stage
import ooo_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dec_valid,
    input  alu_op_t           dec_op,
    input  logic              dec_use_imm,
    input  logic [XLEN-1:0]   dec_imm,
    input  logic [AREG_W-1:0] dec_rs1,
    input  logic [AREG_W-1:0] dec_rs2,
    input  logic [AREG_W-1:0] dec_rd,
    input  logic              free_valid,
    input  logic [PREG_W-1:0] free_preg,
    output logic              ren_valid,
    output alu_op_t           ren_op,
    output logic              ren_use_imm,
    output logic [XLEN-1:0]   ren_imm,
    output logic [PREG_W-1:0] ren_prs1,
    output logic [PREG_W-1:0] ren_prs2,
    output logic [PREG_W-1:0] ren_prd,
    output logic [PREG_W-1:0] ren_old_prd,
    output logic [AREG_W-1:0] ren_rd,
    output logic [ROB_W-1:0]  ren_rob
);

// Rename table, arch reg -> phys reg
logic [PREG_W-1:0] rat [ARCH_REGS];

// Circular free list, never holds more than ROB_DEPTH entries
logic [PREG_W-1:0] free_list [ROB_DEPTH];
logic [ROB_W-1:0]  fl_head;
logic [ROB_W-1:0]  fl_tail;
logic [ROB_W-1:0]  rob_tail;
logic              alloc;

// x0 keeps phys reg 0 and takes nothing from the free list
assign alloc = dec_valid && (dec_rd != '0);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < ARCH_REGS; i++) begin
            rat[i] <= PREG_W'(i);
        end
        for (int i = 0; i < ROB_DEPTH; i++) begin
            free_list[i] <= PREG_W'(ARCH_REGS + i);
        end
        fl_head   <= '0;
        fl_tail   <= '0;
        rob_tail  <= '0;
        ren_valid <= 1'b0;
    end else begin
        ren_valid <= dec_valid;
        if (dec_valid) begin
            rob_tail <= rob_tail + 1'b1;
        end
        if (alloc) begin
            rat[dec_rd] <= free_list[fl_head];
            fl_head     <= fl_head + 1'b1;
        end
        // Old mapping comes back at commit
        if (free_valid) begin
            free_list[fl_tail] <= free_preg;
            fl_tail            <= fl_tail + 1'b1;
        end
    end
end

// Sources see the table before this instruction's own update
always_ff @(posedge clk) begin
    if (dec_valid) begin
        ren_op      <= dec_op;
        ren_use_imm <= dec_use_imm;
        ren_imm     <= dec_imm;
        ren_prs1    <= rat[dec_rs1];
        ren_prs2    <= rat[dec_rs2];
        ren_prd     <= alloc ? free_list[fl_head] : '0;
        ren_old_prd <= rat[dec_rd];
        ren_rd      <= dec_rd;
        ren_rob     <= rob_tail;
    end
end

endmodule : rename_stage

// ==== design/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer
import ooo_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ren_valid,
    input  logic [ROB_W-1:0]  ren_rob,
    input  logic [AREG_W-1:0] ren_rd,
    input  logic [PREG_W-1:0] ren_old_prd,
    input  logic              cdb_valid,
    input  logic [ROB_W-1:0]  cdb_rob,
    input  logic [XLEN-1:0]   cdb_data,
    output logic              commit_valid,
    output logic [AREG_W-1:0] commit_rd,
    output logic [XLEN-1:0]   commit_data,
    output logic              credit_return,
    output logic              free_valid,
    output logic [PREG_W-1:0] free_preg
);

logic [ROB_DEPTH-1:0] done;
logic [AREG_W-1:0]    rob_rd      [ROB_DEPTH];
logic [PREG_W-1:0]    rob_old_prd [ROB_DEPTH];
logic [XLEN-1:0]      rob_data    [ROB_DEPTH];
logic [ROB_W-1:0]     head;

// Head retires as soon as its result is in
assign commit_valid  = done[head];
assign commit_rd     = rob_rd[head];
assign commit_data   = rob_data[head];
assign credit_return = commit_valid;

// Previous mapping of rd is dead once this one commits
assign free_valid = commit_valid && (rob_rd[head] != '0);
assign free_preg  = rob_old_prd[head];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        done <= '0;
        head <= '0;
    end else begin
        if (ren_valid) begin
            done[ren_rob] <= 1'b0;
        end
        if (cdb_valid) begin
            done[cdb_rob] <= 1'b1;
        end
        if (commit_valid) begin
            done[head] <= 1'b0;
            head       <= head + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (ren_valid) begin
        rob_rd[ren_rob]      <= ren_rd;
        rob_old_prd[ren_rob] <= ren_old_prd;
    end
    if (cdb_valid) begin
        rob_data[cdb_rob] <= cdb_data;
    end
end

endmodule : reorder_buffer

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_ooo_core \
    --Mdir obj_dir -o tb_ooo_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ooo_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tb.f ====
design/ooo_pkg.sv
design/inst_decode.sv
design/rename_stage.sv
design/issue_queue.sv
design/phys_reg_file.sv
design/alu_exec.sv
design/reorder_buffer.sv
design/ooo_core.sv
testbench/tb_clock.sv
testbench/tb_ooo_core.sv

// ==== testbench/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

// 4 ns period
initial begin
    clk = 1'b0;
    forever begin
        #2 clk = ~clk;
    end
end

endmodule : tb_clock

// ==== testbench/tb_ooo_core.sv ====
`timescale 1ns/10ps

module tb_ooo_core
import ooo_pkg::*;
();

logic              clk;
logic              rst_n;
logic              inst_valid;
logic [XLEN-1:0]   inst;
logic              credit_return;
logic              commit_valid;
logic [AREG_W-1:0] commit_rd;
logic [XLEN-1:0]   commit_data;

// One row per test, mode 0 back to back, 1 random gaps, 2 credit stall check
string             test_name  [$];
int                test_first [$];
int                test_count [$];
int                test_mode  [$];
logic [XLEN-1:0]   prog       [$];
logic [AREG_W-1:0] exp_rd     [$];
logic [XLEN-1:0]   exp_data   [$];
logic [XLEN-1:0]   arch_regs  [ARCH_REGS];

integer seed;
bit     table_ready;
int     cur_test;
int     exp_ptr;
int     exp_limit;
int     sent_count;
int     returned_count;
int     test_errs;
int     error_total;
int     pass_count;
int     fail_count;
int     watchdog_cycles;

tb_clock tb_clock_inst (.clk(clk));

ooo_core ooo_core_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .credit_return (credit_return),
    .commit_valid  (commit_valid),
    .commit_rd     (commit_rd),
    .commit_data   (commit_data)
);

function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return int'($unsigned(r) % n);
endfunction

// RV32I result for funct3, alt is instruction bit 30 where it applies
function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] wide;
    wide = {{XLEN{a[XLEN-1]}}, a} >> b[4:0];
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? wide[XLEN-1:0] : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// Appends one instruction and the commit the model expects from it
task automatic add_inst(input logic [XLEN-1:0] word);
    logic [AREG_W-1:0] rd;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   res;
    rd = word[11:7];
    a  = arch_regs[word[19:15]];
    case (word[6:0])
        7'b0110011: res = alu_ref(word[14:12], word[30], a, arch_regs[word[24:20]]);
        7'b0010011: res = alu_ref(word[14:12], word[30] && word[14:12] == 3'd5, a,
                                  {{20{word[31]}}, word[31:20]});
        7'b0110111: res = {word[31:12], 12'b0};
        default: begin
            rd  = '0;
            res = '0;
        end
    endcase
    if (rd != '0) begin
        arch_regs[rd] = res;
    end
    prog.push_back(word);
    exp_rd.push_back(rd);
    exp_data.push_back(res);
endtask

task automatic op_r(input logic [6:0] f7, input logic [2:0] f3, input int rd, input int rs1,
                    input int rs2);
    add_inst({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011});
endtask

task automatic op_i(input logic [2:0] f3, input int rd, input int rs1, input int imm);
    add_inst({12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011});
endtask

task automatic op_lui(input int rd, input logic [19:0] imm);
    add_inst({imm, 5'(rd), 7'b0110111});
endtask

task automatic open_test(input string name, input int mode);
    test_name.push_back(name);
    test_first.push_back(prog.size());
    test_mode.push_back(mode);
endtask

task automatic close_test();
    test_count.push_back(prog.size() - test_first[test_first.size() - 1]);
endtask

task automatic build_table();
    int f3;
    int alt;
    for (int i = 0; i < ARCH_REGS; i++) begin
        arch_regs[i] = '0;
    end
    open_test("idle_after_reset", 0);
    close_test();
    open_test("independent_imm", 1);
    op_i(3'd0, 1, 0, 100);
    op_i(3'd4, 2, 0, 'h5a5);
    op_i(3'd2, 3, 0, -1);
    op_i(3'd2, 4, 0, 1);
    op_lui(5, 20'habcde);
    op_i(3'd0, 6, 0, -2048);
    op_i(3'd4, 7, 0, -1);
    close_test();
    open_test("dependent_chain", 1);
    op_i(3'd0, 1, 0, -40);
    op_i(3'd0, 2, 0, 3);
    op_r(7'h00, 3'd0, 3, 1, 2);
    op_r(7'h20, 3'd0, 3, 3, 2);
    op_r(7'h00, 3'd1, 3, 3, 2);
    op_r(7'h20, 3'd5, 3, 3, 2);
    op_r(7'h00, 3'd3, 4, 2, 3);
    op_r(7'h00, 3'd0, 3, 3, 4);
    close_test();
    open_test("x0_writes", 1);
    op_i(3'd0, 0, 0, 55);
    op_r(7'h00, 3'd0, 0, 1, 2);
    op_i(3'd0, 5, 0, 7);
    op_lui(0, 20'h12345);
    op_r(7'h00, 3'd0, 6, 0, 0);
    op_r(7'h00, 3'd6, 7, 0, 5);
    close_test();
    // Serial chain commits slower than the driver sends
    open_test("credit_stall", 2);
    op_i(3'd0, 8, 0, 'h35);
    for (int k = 0; k < 19; k++) begin
        if (k % 2 == 0) begin
            op_i(3'd0, 9, 9, k + 1);
        end else begin
            op_r(7'h00, 3'd4, 9, 9, 8);
        end
    end
    close_test();
    open_test("random_mix", 1);
    for (int k = 0; k < 100; k++) begin
        f3  = rand_below(8);
        alt = rand_below(2);
        case (rand_below(3))
            0: op_r((alt == 1 && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00, 3'(f3),
                    rand_below(6), rand_below(6), rand_below(6));
            1: begin
                if (f3 == 1 || f3 == 5) begin
                    op_i(3'(f3), rand_below(6), rand_below(6),
                         ((alt == 1 && f3 == 5) ? 'h400 : 0) + rand_below(32));
                end else begin
                    op_i(3'(f3), rand_below(6), rand_below(6), rand_below(4096) - 2048);
                end
            end
            default: op_lui(rand_below(6), 20'($random(seed)));
        endcase
    end
    close_test();
endtask

task automatic flag_error();
    test_errs++;
    error_total++;
endtask

task automatic run_test(input int t);
    int last;
    int idx;
    int gap_left;
    int peak;
    int stalls;
    int waited;
    int returned_start;
    last           = test_first[t] + test_count[t];
    idx            = test_first[t];
    gap_left       = 0;
    peak           = 0;
    stalls         = 0;
    waited         = 0;
    cur_test       = t;
    test_errs      = 0;
    exp_limit      = last;
    returned_start = returned_count;
    while (idx < last) begin
        @(posedge clk);
        if (gap_left > 0) begin
            inst_valid <= 1'b0;
            gap_left--;
        end else if (sent_count - returned_count >= INIT_CREDITS) begin
            inst_valid <= 1'b0;
            stalls++;
        end else begin
            inst_valid <= 1'b1;
            inst       <= prog[idx];
            idx++;
            sent_count++;
            if (sent_count - returned_count > peak) begin
                peak = sent_count - returned_count;
            end
            if (test_mode[t] == 1) begin
                gap_left = rand_below(4);
            end
        end
    end
    @(posedge clk);
    inst_valid <= 1'b0;
    if (test_count[t] == 0) begin
        repeat (20) @(posedge clk);
    end
    while (exp_ptr < last && waited < test_count[t] * 40 + 50) begin
        @(posedge clk);
        waited++;
    end
    if (exp_ptr < last) begin
        $display("ERROR: %s ended with %0d commits missing", test_name[t], last - exp_ptr);
        flag_error();
    end
    if (returned_count - returned_start != test_count[t]) begin
        $display("ERROR: %s got %0d credit returns for %0d instructions", test_name[t],
                 returned_count - returned_start, test_count[t]);
        flag_error();
    end
    if (test_mode[t] == 2 && (peak != INIT_CREDITS || stalls == 0)) begin
        $display("ERROR: %s never used up all %0d credits", test_name[t], INIT_CREDITS);
        flag_error();
    end
    if (test_errs == 0) begin
        $display("PASSED %s", test_name[t]);
        pass_count++;
    end else begin
        $display("FAILED %s with %0d errors", test_name[t], test_errs);
        fail_count++;
    end
endtask

// Outputs are sampled mid-cycle
always @(negedge clk) begin
    if (rst_n) begin
        if ($isunknown({commit_valid, credit_return}) || credit_return !== commit_valid) begin
            $display("ERROR: credit_return does not match commit_valid");
            flag_error();
        end
        if (credit_return === 1'b1) begin
            if (sent_count == returned_count) begin
                $display("ERROR: credit_return with no instructions outstanding");
                flag_error();
            end else begin
                returned_count++;
            end
        end
        // Credits only cover instructions that have really committed
        if (sent_count - exp_ptr > INIT_CREDITS) begin
            $display("ERROR: driver exceeded its credits with %0d instructions uncommitted",
                     sent_count - exp_ptr);
            flag_error();
        end
        if (commit_valid === 1'b1) begin
            if (exp_ptr < exp_limit) begin
                if (commit_rd !== exp_rd[exp_ptr]) begin
                    $display("FAILED %s: commit %0d rd expected %0d, actual %0d",
                             test_name[cur_test], exp_ptr - test_first[cur_test],
                             exp_rd[exp_ptr], commit_rd);
                    flag_error();
                end
                if (commit_data !== exp_data[exp_ptr]) begin
                    $display("FAILED %s: commit %0d data expected %h, actual %h",
                             test_name[cur_test], exp_ptr - test_first[cur_test],
                             exp_data[exp_ptr], commit_data);
                    flag_error();
                end
                exp_ptr++;
            end else begin
                $display("ERROR: commit of x%0d when no commit was expected", commit_rd);
                flag_error();
            end
        end
    end
end

initial begin
    wait (table_ready);
    repeat (watchdog_cycles) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles", watchdog_cycles);
    $display("Test FAILED");
    $finish;
end

initial begin
    rst_n          = 1'b0;
    inst_valid     = 1'b0;
    inst           = '0;
    seed           = 32'he8675961;
    table_ready    = 1'b0;
    exp_ptr        = 0;
    exp_limit      = 0;
    cur_test       = 0;
    sent_count     = 0;
    returned_count = 0;
    test_errs      = 0;
    error_total    = 0;
    pass_count     = 0;
    fail_count     = 0;
    build_table();
    watchdog_cycles = prog.size() * 40 + 200;
    table_ready     = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 0; t < test_name.size(); t++) begin
        run_test(t);
    end
    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0 && error_total == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

endmodule : tb_ooo_core
